/* include/soc_settings.svh */
// ==========================================================================
// Build-time sizes of the system fabric: bus widths, address map sizes,
// device ids, register offsets and the reset counter width.
// Include this file wherever one of these macros is needed.
// ==========================================================================
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 30
`define SOC_SEL_W 4

// Map sizes in bytes
`define SOC_RAM_MAPSZ 32'h1000
`define SOC_DEV_MAPSZ 32'h100
`define SOC_INVALID_MAPSZ 32'h1000

// Ids reported by the device table
`define SOC_ID_RAM 1
`define SOC_ID_DEVTBL 7
`define SOC_ID_INTCTRL 3
`define SOC_ID_INVALID 0

`define SOC_RSTREG_OFFSET 15
`define SOC_INT_SRC_COUNT 2
`define SOC_RST_CNTR_W 6

`endif

/* design/soc_pkg.sv */
// ==========================================================================
// Shared types of the system fabric: bus opcodes, slave indices and the
// address and data word types. Modules import it inside their body.
// ==========================================================================
`default_nettype none

`include "soc_settings.svh"

package soc_pkg;

	// Bus opcodes, OP_NONE means no request
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_SWAP  = 2'd3
	} pi1_op_e;

	// Slave indices in address map order
	typedef enum logic [1:0] {
		SLV_RAM     = 2'd0,
		SLV_DEVTBL  = 2'd1,
		SLV_INTCTRL = 2'd2,
		SLV_INVALID = 2'd3
	} slave_idx_e;

	typedef logic [`SOC_DATA_W-1:0] word_t;
	typedef logic [`SOC_ADDR_W-1:0] waddr_t;
	typedef logic [`SOC_SEL_W-1:0] sel_t;

endpackage

`default_nettype wire

/* design/pi1_bus_if.sv */
// ==========================================================================
// One request/response bus link. The master holds op, addr, wdata and sel
// until the cycle where op is not OP_NONE and rdy is high.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

interface pi1_bus_if;
	import soc_pkg::*;

	pi1_op_e op;
	waddr_t addr;
	word_t wdata;
	sel_t sel;
	word_t rdata;
	logic rdy;

	modport master (output op, addr, wdata, sel, input rdata, rdy);

	modport slave (input op, addr, wdata, sel, output rdata, rdy);

endinterface

`default_nettype wire

/* design/rst_sequencer.sv */
// ==========================================================================
// Reset sequencer. rst_p or a software warm reset reloads a down-counter
// and the fabric stays in reset until it reaches zero. A power-off
// request is latched until the next rst_p.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module rst_sequencer (
	 input  wire logic clk24mhz
	,input  wire logic rst_p
	,input  wire logic warm_rst_req_i
	,input  wire logic pwroff_req_i
	,output logic      sys_rst_o
	,output logic      pwroff_o
);

	logic [`SOC_RST_CNTR_W-1:0] rst_cntr;

	// Reload on any reset source, otherwise count down and stop at zero
	always_ff @(posedge clk24mhz) begin
		if (rst_p || warm_rst_req_i) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0);

	// Only a board reset clears the power-off request
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pwroff_o <= 1'b0;
		end else if (pwroff_req_i) begin
			pwroff_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/scratch_ram.sv */
// ==========================================================================
// Scratch RAM of 32-bit words with byte selects. Supports read, write and
// swap; a swap returns the old word while writing the selected bytes.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module scratch_ram (
	 input wire logic clk24mhz
	,input wire logic sys_rst_i
	,pi1_bus_if.slave bus
);
	import soc_pkg::*;

	localparam int RAM_WORDS = `SOC_RAM_MAPSZ / 4;
	localparam int IDX_W = $clog2(RAM_WORDS);

	word_t mem [RAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic accept;

	assign idx    = bus.addr[IDX_W-1:0];
	assign accept = (bus.op != OP_NONE) && !bus.rdy;

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			bus.rdy <= 1'b0;
		end else begin
			bus.rdy <= accept;
		end
	end

	// Old word is captured on the same edge that writes the new bytes
	always_ff @(posedge clk24mhz) begin
		if (accept) begin
			bus.rdata <= mem[idx];
			if (bus.op == OP_WRITE || bus.op == OP_SWAP) begin
				for (int b = 0; b < `SOC_SEL_W; b++) begin
					if (bus.sel[b]) begin
						mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/dev_table.sv */
// ==========================================================================
// Device table. Even word 2i holds the id of slave i, bit 31 flagging
// interrupt use, odd word 2i+1 its map size. The reset register takes
// 2 for a warm reset and 1 for power-off.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module dev_table (
	 input wire logic clk24mhz
	,input wire logic sys_rst_i
	,pi1_bus_if.slave bus
	,output logic     warm_rst_req_o
	,output logic     pwroff_req_o
);
	import soc_pkg::*;

	localparam int OFS_W = $clog2(`SOC_DEV_MAPSZ / 4);
	localparam int SLV_COUNT = 4;

	logic [OFS_W-1:0] offset;
	slave_idx_e slv;
	word_t id_word;
	word_t sz_word;
	logic accept;
	logic rst_wr;

	assign offset = bus.addr[OFS_W-1:0];
	assign slv    = slave_idx_e'(offset[2:1]);
	assign accept = (bus.op != OP_NONE) && !bus.rdy;
	assign rst_wr = accept && (bus.op == OP_WRITE) && (offset == OFS_W'(`SOC_RSTREG_OFFSET));

	always_comb begin
		unique case (slv)
			SLV_RAM: begin
				id_word = word_t'(`SOC_ID_RAM);
				sz_word = word_t'(`SOC_RAM_MAPSZ);
			end
			SLV_DEVTBL: begin
				id_word = word_t'(`SOC_ID_DEVTBL);
				sz_word = word_t'(`SOC_DEV_MAPSZ);
			end
			SLV_INTCTRL: begin
				// Only entry with interrupts in use
				id_word = word_t'(`SOC_ID_INTCTRL) | {1'b1, {(`SOC_DATA_W - 1){1'b0}}};
				sz_word = word_t'(`SOC_DEV_MAPSZ);
			end
			default: begin
				id_word = word_t'(`SOC_ID_INVALID);
				sz_word = word_t'(`SOC_INVALID_MAPSZ);
			end
		endcase
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			bus.rdy        <= 1'b0;
			warm_rst_req_o <= 1'b0;
			pwroff_req_o   <= 1'b0;
		end else begin
			bus.rdy        <= accept;
			// Value 3 requests neither
			warm_rst_req_o <= rst_wr && (bus.wdata[1:0] == 2'b10);
			pwroff_req_o   <= rst_wr && (bus.wdata[1:0] == 2'b01);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (accept) begin
			if (offset >= OFS_W'(2 * SLV_COUNT)) begin
				bus.rdata <= '0;
			end else if (offset[0]) begin
				bus.rdata <= sz_word;
			end else begin
				bus.rdata <= id_word;
			end
		end
	end

endmodule

`default_nettype wire

/* design/int_ctrl.sv */
// ==========================================================================
// Interrupt controller for the external sources. A read returns the
// lowest pending index, or all ones with nothing pending; writing index k
// clears that source and pulses its acknowledge for one cycle.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module int_ctrl (
	 input wire logic                          clk24mhz
	,input wire logic                          sys_rst_i
	,pi1_bus_if.slave                          bus
	,input wire logic [`SOC_INT_SRC_COUNT-1:0] irq_i
	,output logic [`SOC_INT_SRC_COUNT-1:0]     irq_ack_o
	,output logic                              irq_o
);
	import soc_pkg::*;

	logic [`SOC_INT_SRC_COUNT-1:0] pending_q;
	logic [`SOC_INT_SRC_COUNT-1:0] clr;
	word_t lowest;
	logic accept;
	logic wr;

	assign accept = (bus.op != OP_NONE) && !bus.rdy;
	assign wr     = accept && (bus.op == OP_WRITE);

	// Scan downward so the lowest pending index wins
	always_comb begin
		lowest = '1;
		for (int k = `SOC_INT_SRC_COUNT - 1; k >= 0; k--) begin
			if (pending_q[k]) begin
				lowest = word_t'(k);
			end
		end
	end

	always_comb begin
		for (int k = 0; k < `SOC_INT_SRC_COUNT; k++) begin
			clr[k] = wr && (bus.wdata == word_t'(k));
		end
	end

	// A source being acknowledged cannot set again in the same cycle
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			pending_q <= '0;
			irq_ack_o <= '0;
			bus.rdy   <= 1'b0;
		end else begin
			pending_q <= (pending_q | (irq_i & ~irq_ack_o)) & ~clr;
			irq_ack_o <= clr;
			bus.rdy   <= accept;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (accept) begin
			bus.rdata <= lowest;
		end
	end

	assign irq_o = |pending_q;

endmodule

`default_nettype wire

/* design/pi1_addr_decoder.sv */
// ==========================================================================
// Address decoder between the bus master and the slaves. Only the slave
// owning the word address sees the request; unmapped addresses go to the
// built-in invalid-address slave, which completes at once and reads zero.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module pi1_addr_decoder (
	 input wire logic  clk24mhz
	,input wire logic  sys_rst_i
	,pi1_bus_if.slave  bus_m
	,pi1_bus_if.master bus_ram
	,pi1_bus_if.master bus_devtbl
	,pi1_bus_if.master bus_intctrl
);
	import soc_pkg::*;

	// Map boundaries as word addresses
	localparam waddr_t DEVTBL_BASE  = waddr_t'(`SOC_RAM_MAPSZ / 4);
	localparam waddr_t INTCTRL_BASE = waddr_t'(DEVTBL_BASE + `SOC_DEV_MAPSZ / 4);
	localparam waddr_t MAP_END      = waddr_t'(INTCTRL_BASE + `SOC_DEV_MAPSZ / 4);

	slave_idx_e route_idx;
	slave_idx_e cur_idx_q;
	slave_idx_e active_idx;
	logic busy_q;

	always_comb begin
		if (bus_m.addr < DEVTBL_BASE) begin
			route_idx = SLV_RAM;
		end else if (bus_m.addr < INTCTRL_BASE) begin
			route_idx = SLV_DEVTBL;
		end else if (bus_m.addr < MAP_END) begin
			route_idx = SLV_INTCTRL;
		end else begin
			route_idx = SLV_INVALID;
		end
	end

	// Route is locked to the slave picked in the first cycle of a transfer
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			busy_q <= 1'b0;
		end else if (bus_m.op != OP_NONE) begin
			busy_q <= !bus_m.rdy;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (!busy_q) begin
			cur_idx_q <= route_idx;
		end
	end

	assign active_idx = busy_q ? cur_idx_q : route_idx;

	assign bus_ram.op    = (active_idx == SLV_RAM) ? bus_m.op : OP_NONE;
	assign bus_ram.addr  = bus_m.addr;
	assign bus_ram.wdata = bus_m.wdata;
	assign bus_ram.sel   = bus_m.sel;

	assign bus_devtbl.op    = (active_idx == SLV_DEVTBL) ? bus_m.op : OP_NONE;
	assign bus_devtbl.addr  = bus_m.addr;
	assign bus_devtbl.wdata = bus_m.wdata;
	assign bus_devtbl.sel   = bus_m.sel;

	assign bus_intctrl.op    = (active_idx == SLV_INTCTRL) ? bus_m.op : OP_NONE;
	assign bus_intctrl.addr  = bus_m.addr;
	assign bus_intctrl.wdata = bus_m.wdata;
	assign bus_intctrl.sel   = bus_m.sel;

	// Response mux, the invalid slave answers with zero
	always_comb begin
		unique case (active_idx)
			SLV_RAM: begin
				bus_m.rdata = bus_ram.rdata;
				bus_m.rdy   = bus_ram.rdy;
			end
			SLV_DEVTBL: begin
				bus_m.rdata = bus_devtbl.rdata;
				bus_m.rdy   = bus_devtbl.rdy;
			end
			SLV_INTCTRL: begin
				bus_m.rdata = bus_intctrl.rdata;
				bus_m.rdy   = bus_intctrl.rdy;
			end
			default: begin
				bus_m.rdata = '0;
				bus_m.rdy   = !sys_rst_i;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/soc_fabric.sv */
// ==========================================================================
// Top level of the on-chip fabric. One bus master port reaches the RAM,
// device table, interrupt controller and invalid-address slave through
// the address decoder. The reset sequencer holds everything in reset.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module soc_fabric (
	 input  wire logic                          clk24mhz
	,input  wire logic                          rst_p
	,input  wire soc_pkg::pi1_op_e              op_i
	,input  wire soc_pkg::waddr_t               addr_i
	,input  wire soc_pkg::word_t                wdata_i
	,input  wire soc_pkg::sel_t                 sel_i
	,output      soc_pkg::word_t                rdata_o
	,output logic                               rdy_o
	,input  wire logic [`SOC_INT_SRC_COUNT-1:0] irq_i
	,output logic [`SOC_INT_SRC_COUNT-1:0]      irq_ack_o
	,output logic                               irq_o
	,output logic                               rst_o
	,output logic                               pwroff_o
);
	import soc_pkg::*;

	logic sys_rst;
	logic warm_rst_req;
	logic pwroff_req;

	pi1_bus_if bus_m ();
	pi1_bus_if bus_ram ();
	pi1_bus_if bus_devtbl ();
	pi1_bus_if bus_intctrl ();

	// Master port onto the decoder link
	assign bus_m.op    = op_i;
	assign bus_m.addr  = addr_i;
	assign bus_m.wdata = wdata_i;
	assign bus_m.sel   = sel_i;
	assign rdata_o     = bus_m.rdata;
	assign rdy_o       = bus_m.rdy;

	assign rst_o = sys_rst;

	rst_sequencer u_rst_sequencer (
		 .clk24mhz       (clk24mhz)
		,.rst_p          (rst_p)
		,.warm_rst_req_i (warm_rst_req)
		,.pwroff_req_i   (pwroff_req)
		,.sys_rst_o      (sys_rst)
		,.pwroff_o       (pwroff_o)
	);

	pi1_addr_decoder u_pi1_addr_decoder (
		 .clk24mhz    (clk24mhz)
		,.sys_rst_i   (sys_rst)
		,.bus_m       (bus_m.slave)
		,.bus_ram     (bus_ram.master)
		,.bus_devtbl  (bus_devtbl.master)
		,.bus_intctrl (bus_intctrl.master)
	);

	scratch_ram u_scratch_ram (
		 .clk24mhz  (clk24mhz)
		,.sys_rst_i (sys_rst)
		,.bus       (bus_ram.slave)
	);

	dev_table u_dev_table (
		 .clk24mhz       (clk24mhz)
		,.sys_rst_i      (sys_rst)
		,.bus            (bus_devtbl.slave)
		,.warm_rst_req_o (warm_rst_req)
		,.pwroff_req_o   (pwroff_req)
	);

	int_ctrl u_int_ctrl (
		 .clk24mhz  (clk24mhz)
		,.sys_rst_i (sys_rst)
		,.bus       (bus_intctrl.slave)
		,.irq_i     (irq_i)
		,.irq_ack_o (irq_ack_o)
		,.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_soc_fabric.sv */
// ============================================================================
// Testbench for the system fabric. Drives the master port through reset,
// RAM, device table, invalid-address, interrupt and software reset tests,
// checks every response against a reference model and reports the result.
// ============================================================================
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_fabric;
	import soc_pkg::*;

	localparam int RAM_OPS = 200;
	localparam int SLOTS = 16;
	localparam int INVALID_OPS = 16;
	localparam int TABLE_WORDS = `SOC_DEV_MAPSZ / 4;
	// The tests take about 1300 cycles, three times that is the limit
	localparam int TIMEOUT_CYCLES = 4000;
	localparam waddr_t DEVTBL_W = waddr_t'(`SOC_RAM_MAPSZ / 4);
	localparam waddr_t INTCTRL_W = DEVTBL_W + waddr_t'(`SOC_DEV_MAPSZ / 4);
	localparam waddr_t INVALID_W = INTCTRL_W + waddr_t'(`SOC_DEV_MAPSZ / 4);
	localparam waddr_t RSTREG_W = DEVTBL_W + waddr_t'(`SOC_RSTREG_OFFSET);

	logic clk24mhz = 1'b0;
	logic rst_p;
	pi1_op_e op_i;
	waddr_t addr_i;
	word_t wdata_i;
	sel_t sel_i;
	word_t rdata_o;
	logic rdy_o;
	logic [`SOC_INT_SRC_COUNT-1:0] irq_i;
	logic [`SOC_INT_SRC_COUNT-1:0] irq_ack_o;
	logic irq_o;
	logic rst_o;
	logic pwroff_o;

	// Reference state
	word_t ram_model [1024];
	waddr_t slot_addr [SLOTS];
	logic [`SOC_INT_SRC_COUNT-1:0] pend_model;
	logic [`SOC_INT_SRC_COUNT-1:0] ack_seen;

	int cycles = 0;
	int err_count = 0;
	int check_count = 0;
	int test_errs = 0;
	int test_checks = 0;
	int test_count = 0;

	always #4 clk24mhz = ~clk24mhz;

	soc_fabric u_soc_fabric (
		 .clk24mhz  (clk24mhz)
		,.rst_p     (rst_p)
		,.op_i      (op_i)
		,.addr_i    (addr_i)
		,.wdata_i   (wdata_i)
		,.sel_i     (sel_i)
		,.rdata_o   (rdata_o)
		,.rdy_o     (rdy_o)
		,.irq_i     (irq_i)
		,.irq_ack_o (irq_ack_o)
		,.irq_o     (irq_o)
		,.rst_o     (rst_o)
		,.pwroff_o  (pwroff_o)
	);

	always @(posedge clk24mhz) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Expected read data for any word address
	function automatic word_t ref_read(input waddr_t addr);
		word_t res;
		int ofs;
		int k;
		res = '0;
		if (addr < DEVTBL_W) begin
			res = ram_model[addr[9:0]];
		end else if (addr < INTCTRL_W) begin
			ofs = int'(addr - DEVTBL_W);
			case (ofs)
				0: res = `SOC_ID_RAM;
				1: res = `SOC_RAM_MAPSZ;
				2: res = `SOC_ID_DEVTBL;
				3: res = `SOC_DEV_MAPSZ;
				4: res = 32'h8000_0000 | `SOC_ID_INTCTRL;
				5: res = `SOC_DEV_MAPSZ;
				6: res = `SOC_ID_INVALID;
				7: res = `SOC_INVALID_MAPSZ;
				default: res = '0;
			endcase
		end else if (addr < INVALID_W) begin
			k = 0;
			while (k < `SOC_INT_SRC_COUNT && !pend_model[k]) begin
				k++;
			end
			res = (k < `SOC_INT_SRC_COUNT) ? word_t'(k) : '1;
		end
		return res;
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t wdata, input sel_t sel);
		word_t res;
		res = old;
		for (int b = 0; b < `SOC_SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		check_count++;
		test_checks++;
		if (actual !== expected) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR: %s", msg);
		err_count++;
		test_errs++;
	endtask

	task automatic report_test(input string name);
		$display("Test %-8s %s, %0d checks, %0d errors", name,
			(test_errs == 0) ? "ok" : "bad", test_checks, test_errs);
		test_count++;
		test_errs = 0;
		test_checks = 0;
	endtask

	// One transfer; a source acknowledged by it is dropped as the request ends
	task automatic bus_xfer(input pi1_op_e op, input waddr_t addr, input word_t wdata,
		input sel_t sel, output word_t rdata);
		logic done;
		done = 1'b0;
		rdata = '0;
		@(posedge clk24mhz);
		op_i <= op;
		addr_i <= addr;
		wdata_i <= wdata;
		sel_i <= sel;
		while (!done) begin
			@(negedge clk24mhz);
			ack_seen = irq_ack_o;
			if (rdy_o) begin
				rdata = rdata_o;
				done = 1'b1;
			end
		end
		@(posedge clk24mhz);
		op_i <= OP_NONE;
		irq_i <= irq_i & ~ack_seen;
	endtask

	initial begin
		word_t rd;
		word_t wd;
		word_t exp;
		waddr_t a;
		sel_t s;
		pi1_op_e op;
		int i;
		int n;
		int r;
		int si;
		void'($urandom(32'h43063f6a));
		rst_p = 1'b1;
		op_i = OP_NONE;
		addr_i = '0;
		wdata_i = '0;
		sel_i = '0;
		irq_i = '0;
		pend_model = '0;
		ack_seen = '0;

		// Reset release with a request already waiting
		repeat (16) @(posedge clk24mhz);
		rst_p <= 1'b0;
		op_i <= OP_READ;
		addr_i <= INVALID_W;
		n = 0;
		@(negedge clk24mhz);
		while (rst_o) begin
			check_value("reset_rdy", '0, word_t'(rdy_o));
			check_value("reset_pwroff", '0, word_t'(pwroff_o));
			check_value("reset_irq", '0, word_t'(irq_o));
			check_value("reset_ack", '0, word_t'(irq_ack_o));
			n++;
			@(negedge clk24mhz);
		end
		if (n > 64) begin
			report_problem("rst_o stayed high for more than 64 cycles after rst_p");
		end
		check_value("reset_done", 32'd1, word_t'(rdy_o));
		check_value("reset_rdata", '0, rdata_o);
		@(posedge clk24mhz);
		op_i <= OP_NONE;
		report_test("reset");

		// RAM slots get known contents first
		for (i = 0; i < SLOTS; i++) begin
			slot_addr[i] = waddr_t'($urandom % 1024);
			wd = $urandom;
			bus_xfer(OP_WRITE, slot_addr[i], wd, '1, rd);
			ram_model[slot_addr[i][9:0]] = wd;
		end
		for (i = 0; i < RAM_OPS; i++) begin
			si = int'($urandom % SLOTS);
			a = slot_addr[si];
			wd = $urandom;
			s = sel_t'($urandom);
			r = int'($urandom % 3);
			case (r)
				0: op = OP_WRITE;
				1: op = OP_READ;
				default: op = OP_SWAP;
			endcase
			exp = ref_read(a);
			bus_xfer(op, a, wd, s, rd);
			if (op != OP_WRITE) begin
				check_value("ram_ops", exp, rd);
			end
			if (op != OP_READ) begin
				ram_model[a[9:0]] = merge_bytes(exp, wd, s);
			end
		end
		for (i = 0; i < SLOTS; i++) begin
			bus_xfer(OP_READ, slot_addr[i], '0, '1, rd);
			check_value("ram_final", ref_read(slot_addr[i]), rd);
		end
		report_test("ram");

		// Whole device table, unused words too
		for (i = 0; i < TABLE_WORDS; i++) begin
			a = DEVTBL_W + waddr_t'(i);
			bus_xfer(OP_READ, a, '0, '1, rd);
			check_value("dev_table", ref_read(a), rd);
		end
		report_test("devtbl");

		// Writes alias onto used RAM slots, reads go anywhere unmapped
		for (i = 0; i < INVALID_OPS; i++) begin
			si = int'($urandom % SLOTS);
			a = waddr_t'((($urandom % 32'hF_FFFE) + 32'd2) << 10) | slot_addr[si];
			bus_xfer(OP_WRITE, a, $urandom, '1, rd);
			a = waddr_t'(32'h480 + $urandom % (32'h4000_0000 - 32'h480));
			bus_xfer(OP_READ, a, '0, '1, rd);
			check_value("invalid_read", ref_read(a), rd);
		end
		for (i = 0; i < SLOTS; i++) begin
			bus_xfer(OP_READ, slot_addr[i], '0, '1, rd);
			check_value("invalid_ram", ref_read(slot_addr[i]), rd);
		end
		report_test("invalid");

		// Both sources raised, then acknowledged one at a time
		@(posedge clk24mhz);
		irq_i <= '1;
		pend_model = '1;
		while (!irq_o) begin
			@(negedge clk24mhz);
		end
		bus_xfer(OP_READ, INTCTRL_W, '0, '1, rd);
		check_value("irq_first", ref_read(INTCTRL_W), rd);
		bus_xfer(OP_WRITE, INTCTRL_W, 32'd0, '1, rd);
		pend_model[0] = 1'b0;
		check_value("irq_ack0", 32'd1, word_t'(ack_seen));
		@(negedge clk24mhz);
		check_value("irq_ack0_end", '0, word_t'(irq_ack_o));
		check_value("irq_still", 32'd1, word_t'(irq_o));
		bus_xfer(OP_READ, INTCTRL_W, '0, '1, rd);
		check_value("irq_second", ref_read(INTCTRL_W), rd);
		bus_xfer(OP_WRITE, INTCTRL_W, 32'd1, '1, rd);
		pend_model[1] = 1'b0;
		check_value("irq_ack1", 32'd2, word_t'(ack_seen));
		@(negedge clk24mhz);
		check_value("irq_ack1_end", '0, word_t'(irq_ack_o));
		check_value("irq_low", '0, word_t'(irq_o));
		bus_xfer(OP_READ, INTCTRL_W, '0, '1, rd);
		check_value("irq_none", ref_read(INTCTRL_W), rd);
		report_test("irq");

		// Warm reset keeps RAM contents
		wd = $urandom;
		a = slot_addr[0];
		bus_xfer(OP_WRITE, a, wd, '1, rd);
		ram_model[a[9:0]] = wd;
		bus_xfer(OP_WRITE, RSTREG_W, 32'd2, '1, rd);
		while (!rst_o) begin
			@(negedge clk24mhz);
		end
		n = 0;
		while (rst_o) begin
			n++;
			@(negedge clk24mhz);
		end
		if (n > 64) begin
			report_problem("rst_o stayed high for more than 64 cycles after a warm reset");
		end
		bus_xfer(OP_READ, a, '0, '1, rd);
		check_value("warm_ram", ref_read(a), rd);
		check_value("warm_pwroff", '0, word_t'(pwroff_o));

		// Power-off holds until the board reset
		bus_xfer(OP_WRITE, RSTREG_W, 32'd1, '1, rd);
		@(negedge clk24mhz);
		check_value("pwroff_set", 32'd1, word_t'(pwroff_o));
		check_value("pwroff_no_rst", '0, word_t'(rst_o));
		repeat (10) @(negedge clk24mhz);
		check_value("pwroff_hold", 32'd1, word_t'(pwroff_o));
		@(posedge clk24mhz);
		rst_p <= 1'b1;
		repeat (16) @(posedge clk24mhz);
		rst_p <= 1'b0;
		@(negedge clk24mhz);
		check_value("pwroff_clear", '0, word_t'(pwroff_o));
		while (rst_o) begin
			@(negedge clk24mhz);
		end
		report_test("swreset");

		$display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			err_count);
		if (err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* soc_fabric.f */
+incdir+include
design/soc_pkg.sv
design/pi1_bus_if.sv
design/rst_sequencer.sv
design/scratch_ram.sv
design/dev_table.sv
design/int_ctrl.sv
design/pi1_addr_decoder.sv
design/soc_fabric.sv
testbench/tb_soc_fabric.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the fabric testbench with Verilator and runs it.
# The exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 \
	--top-module tb_soc_fabric \
	-f soc_fabric.f \
	-Mdir obj_dir -o tb_soc_fabric \
	&& ./obj_dir/tb_soc_fabric 2>&1 | tee sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
